// ==== src/mem_pkg.sv ====
// Memory widths, slot request and response structs, region offsets, slot indices, mux states
package mem_pkg;

    // SDRAM side word address
    typedef logic [21:0] sdram_addr_t;
    // Word address inside one client region
    typedef logic [19:0] slot_addr_t;
    typedef logic [15:0] word_t;
    // Active low byte enables, bit 1 is the upper byte
    typedef logic [1:0]  byte_mask_t;
    // Byte address of the ROM download stream
    typedef logic [22:0] dl_addr_t;

    localparam int NUM_SLOTS_MAX = 4;

    // Client slot indices
    localparam int SLOT_MAIN_ROM = 0;
    localparam int SLOT_RAM      = 1;
    localparam int SLOT_GFX      = 2;
    localparam int SLOT_SOUND    = 3;

    // Request held by a client until ok
    typedef struct packed {
        logic       cs;
        logic       wr;
        slot_addr_t addr;
        word_t      din;
        byte_mask_t wrmask;
    } slot_req_t;

    typedef struct packed {
        logic  ok;
        word_t dout;
    } slot_rsp_t;

    // Base of each client region in SDRAM
    localparam sdram_addr_t REGION_OFFSET [0:NUM_SLOTS_MAX-1] = '{
        SLOT_MAIN_ROM : 22'h00_0000,
        SLOT_RAM      : 22'h3A_8000,
        SLOT_GFX      : 22'h0A_8000,
        SLOT_SOUND    : 22'h08_0000
    };

    typedef enum logic [1:0] {IDLE, REQ, WAIT_DATA, RESPOND} mux_state_t;

endpackage

// ==== src/frac_cen.sv ====
// Fractional clock enable generator with CEN_N pulses in every CEN_M cycles
`timescale 1ns/1ps

module frac_cen #(
    parameter int CEN_N = 5,
    parameter int CEN_M = 24
) (
    input  logic VB,
    input  logic rst_n,
    output logic cen
);

    // Wide enough for the largest sum before the wrap
    localparam int ACC_W = $clog2(CEN_M + CEN_N);

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] sum;
    logic             wrap;

    assign sum  = acc + ACC_W'(CEN_N);
    assign wrap = (sum >= ACC_W'(CEN_M));

    // The accumulator returns to the same value every CEN_M cycles
    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            cen <= 1'b0;
        end else begin
            if (wrap) begin
                acc <= sum - ACC_W'(CEN_M);
            end else begin
                acc <= sum;
            end
            cen <= wrap;
        end
    end

endmodule

// ==== src/prom_writer.sv ====
// Download byte stream to masked SDRAM programming writes and configuration strobes
`timescale 1ns/1ps

module prom_writer #(
    parameter mem_pkg::dl_addr_t CFG_START = 23'h40_0000
) (
    input  logic                 VB,
    input  logic                 rst_n,
    input  logic                 downloading,
    input  mem_pkg::dl_addr_t    ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    input  logic                 sdram_ack,
    output mem_pkg::sdram_addr_t prog_addr,
    output logic [7:0]           prog_data,
    output mem_pkg::byte_mask_t  prog_mask,
    output logic                 prog_we,
    output logic                 cfg_we
);
    import mem_pkg::*;

    // Active low masks, even byte addresses land in the upper byte
    localparam byte_mask_t MASK_UPPER = 2'b01;
    localparam byte_mask_t MASK_LOWER = 2'b10;

    logic accept;
    logic is_cfg;

    // Bytes arriving during a pending write are lost
    assign accept = downloading && ioctl_wr && !prog_we;
    assign is_cfg = (ioctl_addr >= CFG_START);

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            cfg_we  <= 1'b0;
        end else begin
            cfg_we <= 1'b0;
            if (prog_we) begin
                if (sdram_ack) begin
                    prog_we <= 1'b0;
                end
            end else if (accept) begin
                if (is_cfg) begin
                    cfg_we <= 1'b1;
                end else begin
                    prog_we <= 1'b1;
                end
            end
        end
    end

    // Data also feeds the configuration registers
    always_ff @(posedge VB) begin
        if (accept) begin
            prog_data <= ioctl_data;
            if (!is_cfg) begin
                prog_addr <= ioctl_addr[22:1];
                prog_mask <= ioctl_addr[0] ? MASK_LOWER : MASK_UPPER;
            end
        end
    end

endmodule

// ==== src/sdram_slot_mux.sv ====
// Fixed priority slot arbiter with region offsets and the SDRAM request sequence
`timescale 1ns/1ps

module sdram_slot_mux #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                                  VB,
    input  logic                                  rst_n,
    input  logic                                  downloading,
    input  mem_pkg::slot_req_t [NUM_SLOTS-1:0]    slot_req,
    output mem_pkg::slot_rsp_t [NUM_SLOTS-1:0]    slot_rsp,
    output logic                                  sdram_req,
    output mem_pkg::sdram_addr_t                  sdram_addr,
    output logic                                  sdram_rnw,
    output mem_pkg::byte_mask_t                   sdram_wrmask,
    output mem_pkg::word_t                        data_write,
    input  logic                                  sdram_ack,
    input  logic                                  data_rdy,
    input  mem_pkg::word_t                        data_read
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(NUM_SLOTS);

    mux_state_t           state;
    logic [IDX_W-1:0]     gnt_q;
    logic [NUM_SLOTS-1:0] ok_q;
    word_t                dout_q [NUM_SLOTS];

    logic                 gnt_valid;
    logic [IDX_W-1:0]     gnt_idx;
    sdram_addr_t          gnt_addr;
    slot_req_t            gnt_req;

    // Lowest index wins, so scan from the top down
    always_comb begin
        gnt_valid = 1'b0;
        gnt_idx   = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (slot_req[i].cs) begin
                gnt_valid = 1'b1;
                gnt_idx   = IDX_W'(i);
            end
        end
    end

    assign gnt_req  = slot_req[gnt_idx];
    assign gnt_addr = REGION_OFFSET[gnt_idx] + sdram_addr_t'(gnt_req.addr);

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_rsp[i].ok   = ok_q[i];
            slot_rsp[i].dout = dout_q[i];
        end
    end

    // Request sequence
    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            gnt_q     <= '0;
            ok_q      <= '0;
            sdram_req <= 1'b0;
        end else begin
            unique case (state)
                IDLE: begin
                    // No new grants while the ROM download owns the SDRAM
                    if (gnt_valid && !downloading) begin
                        gnt_q     <= gnt_idx;
                        sdram_req <= 1'b1;
                        state     <= REQ;
                    end
                end
                REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_rdy) begin
                        ok_q[gnt_q] <= 1'b1;
                        state       <= RESPOND;
                    end
                end
                RESPOND: begin
                    // Back to IDLE so the served client can drop cs
                    ok_q  <= '0;
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Payload of the granted request
    always_ff @(posedge VB) begin
        if (state == IDLE && gnt_valid && !downloading) begin
            sdram_addr   <= gnt_addr;
            sdram_rnw    <= ~gnt_req.wr;
            sdram_wrmask <= gnt_req.wrmask;
            data_write   <= gnt_req.din;
        end
    end

    // Read data return, writes keep the last value
    always_ff @(posedge VB) begin
        if (state == WAIT_DATA && data_rdy && sdram_rnw) begin
            dout_q[gnt_q] <= data_read;
        end
    end

endmodule

// ==== src/game_mem_top.sv ====
// Memory side top level with CPU clock enable, download writer and slot multiplexer
`timescale 1ns/1ps

module game_mem_top #(
    parameter int                CEN_N     = 5,
    parameter int                CEN_M     = 24,
    parameter mem_pkg::dl_addr_t CFG_START = 23'h40_0000,
    parameter int                NUM_SLOTS = 4
) (
    input  logic                               VB,
    input  logic                               rst_n,
    input  logic                               downloading,
    // ROM download
    input  mem_pkg::dl_addr_t                  ioctl_addr,
    input  logic [7:0]                         ioctl_data,
    input  logic                               ioctl_wr,
    output mem_pkg::sdram_addr_t               prog_addr,
    output logic [7:0]                         prog_data,
    output mem_pkg::byte_mask_t                prog_mask,
    output logic                               prog_we,
    output logic                               cfg_we,
    // Client slots
    input  mem_pkg::slot_req_t [NUM_SLOTS-1:0] slot_req,
    output mem_pkg::slot_rsp_t [NUM_SLOTS-1:0] slot_rsp,
    // SDRAM controller
    output logic                               sdram_req,
    output mem_pkg::sdram_addr_t               sdram_addr,
    output logic                               sdram_rnw,
    output mem_pkg::byte_mask_t                sdram_wrmask,
    output mem_pkg::word_t                     data_write,
    input  logic                               sdram_ack,
    input  logic                               data_rdy,
    input  mem_pkg::word_t                     data_read,
    output logic                               cpu_cen
);

    frac_cen #(
        .CEN_N ( CEN_N ),
        .CEN_M ( CEN_M )
    ) u_cen (
        .VB    ( VB      ),
        .rst_n ( rst_n   ),
        .cen   ( cpu_cen )
    );

    // Shares sdram_ack with the mux, which idles during the download
    prom_writer #(
        .CFG_START ( CFG_START )
    ) u_prom_we (
        .VB          ( VB          ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .cfg_we      ( cfg_we      )
    );

    sdram_slot_mux #(
        .NUM_SLOTS ( NUM_SLOTS )
    ) u_slot_mux (
        .VB           ( VB           ),
        .rst_n        ( rst_n        ),
        .downloading  ( downloading  ),
        .slot_req     ( slot_req     ),
        .slot_rsp     ( slot_rsp     ),
        .sdram_req    ( sdram_req    ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_rnw    ( sdram_rnw    ),
        .sdram_wrmask ( sdram_wrmask ),
        .data_write   ( data_write   ),
        .sdram_ack    ( sdram_ack    ),
        .data_rdy     ( data_rdy     ),
        .data_read    ( data_read    )
    );

endmodule

// ==== verif/mem_checker.sv ====
// Concurrent assertions on the memory top level ports, bound into game_mem_top
`timescale 1ns/1ps

module mem_checker #(
    parameter int NUM_SLOTS = 4
) (
    input logic                               VB,
    input logic                               rst_n,
    input logic                               downloading,
    input logic                               sdram_req,
    input logic                               prog_we,
    input logic                               cfg_we,
    input mem_pkg::slot_rsp_t [NUM_SLOTS-1:0] slot_rsp
);

    logic [NUM_SLOTS-1:0] ok_vec;
    int                   fail_count = 0;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            ok_vec[i] = slot_rsp[i].ok;
        end
    end

    // Grant decision uses downloading from the edge before the request
    no_req_in_download: assert property (
        @(posedge VB) disable iff (!rst_n) $rose(sdram_req) |-> !$past(downloading)
    ) else begin
        $error("sdram_req raised during the download");
        fail_count++;
    end

    single_ok: assert property (@(posedge VB) disable iff (!rst_n) $onehot0(ok_vec))
    else begin
        $error("more than one slot ok at once");
        fail_count++;
    end

    prog_cfg_apart: assert property (@(posedge VB) disable iff (!rst_n) !(prog_we && cfg_we))
    else begin
        $error("prog_we and cfg_we high together");
        fail_count++;
    end

endmodule

bind game_mem_top mem_checker #(.NUM_SLOTS(NUM_SLOTS)) u_mem_checker (.*);

// ==== verif/tb_game_mem.sv ====
// Testbench with clock, reset, SDRAM model, reference functions, compare tasks and five tests
`timescale 1ns/1ps

module tb_game_mem;
    import mem_pkg::*;

    localparam int       CEN_N     = 5;
    localparam int       CEN_M     = 24;
    localparam dl_addr_t CFG_START = 23'h40_0000;
    localparam int       NUM_SLOTS = 4;
    localparam int       TIMEOUT   = 100;

    logic                      VB = 1'b0;
    logic                      rst_n, downloading, ioctl_wr, prog_we, cfg_we, cpu_cen;
    logic                      sdram_req, sdram_rnw, sdram_ack, data_rdy;
    logic [7:0]                ioctl_data, prog_data;
    dl_addr_t                  ioctl_addr;
    sdram_addr_t               prog_addr, sdram_addr;
    byte_mask_t                prog_mask, sdram_wrmask;
    word_t                     data_write, data_read;
    slot_req_t [NUM_SLOTS-1:0] slot_req;
    slot_rsp_t [NUM_SLOTS-1:0] slot_rsp;

    // Sparse SDRAM contents, only written words are stored
    word_t mem [sdram_addr_t];
    int    errors = 0;
    int    checks = 0;
    int    failed_tests = 0;
    logic  req_in_download = 1'b0;

    game_mem_top #(
        .CEN_N     ( CEN_N     ),
        .CEN_M     ( CEN_M     ),
        .CFG_START ( CFG_START ),
        .NUM_SLOTS ( NUM_SLOTS )
    ) u_game_mem_top (.*);

    always #10 VB = ~VB;

    // Fill pattern of unwritten words, every address bit takes part
    function automatic word_t ref_word(input sdram_addr_t a);
        logic [31:0] mix;
        mix = {a, 10'h0} ^ {10'h0, a};
        return mix[31:16] ^ mix[15:0] ^ 16'h5A3C;
    endfunction

    function automatic sdram_addr_t ref_sdram_addr(input int s, input slot_addr_t a);
        sdram_addr_t base;
        case (s)
            1:       base = 22'h3A_8000;
            2:       base = 22'h0A_8000;
            3:       base = 22'h08_0000;
            default: base = 22'h00_0000;
        endcase
        return base + sdram_addr_t'(a);
    endfunction

    // Even byte addresses enable the upper byte, active low
    function automatic byte_mask_t ref_prog_mask(input dl_addr_t a);
        return a[0] ? 2'b10 : 2'b01;
    endfunction

    function automatic word_t ref_merge(input word_t old, input word_t din, input byte_mask_t m);
        word_t w;
        w = old;
        if (!m[1]) w[15:8] = din[15:8];
        if (!m[0]) w[7:0] = din[7:0];
        return w;
    endfunction

    function automatic word_t read_mem(input sdram_addr_t a);
        return mem.exists(a) ? mem[a] : ref_word(a);
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input sdram_addr_t exp, input sdram_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected address %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input byte_mask_t exp, input byte_mask_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected mask %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERROR %s: expected count %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        errors++;
        $display("%s: gave up after %0d cycles waiting for %s", name, TIMEOUT, what);
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - start);
        end
    endtask

    // SDRAM controller stand-in, one access at a time
    task automatic serve_access();
        logic        is_prog;
        sdram_addr_t a;
        int          delay;
        is_prog = prog_we;
        a = is_prog ? prog_addr : sdram_addr;
        delay = $urandom_range(4, 1);
        repeat (delay - 1) @(posedge VB);
        sdram_ack <= 1'b1;
        @(posedge VB);
        sdram_ack <= 1'b0;
        if (is_prog) begin
            mem[a] = ref_merge(read_mem(a), {prog_data, prog_data}, prog_mask);
        end else begin
            if (!sdram_rnw) mem[a] = ref_merge(read_mem(a), data_write, sdram_wrmask);
            delay = $urandom_range(6, 1);
            repeat (delay - 1) @(posedge VB);
            data_read <= read_mem(a);
            data_rdy  <= 1'b1;
            @(posedge VB);
            data_rdy  <= 1'b0;
        end
    endtask

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge VB);
            if (rst_n && (sdram_req || prog_we)) serve_access();
        end
    end

    always @(posedge VB) begin
        if (downloading && sdram_req) req_in_download <= 1'b1;
    end

    task automatic issue_request(input int s, input logic wr, input slot_addr_t a,
                                 input word_t din, input byte_mask_t m);
        @(posedge VB);
        slot_req[s] <= '{cs: 1'b1, wr: wr, addr: a, din: din, wrmask: m};
    endtask

    task automatic finish_access(input string name, input int s, input logic wr,
                                 input slot_addr_t a, input word_t din,
                                 input byte_mask_t m, output word_t dout);
        int n;
        n = 0;
        dout = '0;
        do begin
            @(posedge VB);
            n++;
        end while (!sdram_req && n < TIMEOUT);
        if (!sdram_req) begin
            report_timeout(name, "sdram_req");
        end else begin
            check_addr(name, ref_sdram_addr(s, a), sdram_addr);
            checks++;
            if (sdram_rnw !== !wr) begin
                errors++;
                $display("ERROR %s: expected sdram_rnw %b, actual %b", name, !wr, sdram_rnw);
            end
            if (wr) begin
                check_mask(name, m, sdram_wrmask);
                check_word(name, din, data_write);
            end
            n = 0;
            do begin
                @(posedge VB);
                n++;
            end while (!slot_rsp[s].ok && n < TIMEOUT);
            if (!slot_rsp[s].ok) report_timeout(name, "ok");
            dout = slot_rsp[s].dout;
        end
        slot_req[s].cs <= 1'b0;
    endtask

    task automatic test_clock_enable();
        int start;
        int cnt;
        int w;
        start = errors;
        for (w = 0; w < 10; w++) begin
            cnt = 0;
            repeat (CEN_M) begin
                @(posedge VB);
                if (cpu_cen) cnt++;
            end
            check_count("clock_enable", CEN_N, cnt);
        end
        report_test("clock_enable", start);
    endtask

    task automatic test_read_path();
        int         start;
        int         s;
        int         i;
        slot_addr_t a;
        word_t      got;
        start = errors;
        for (s = 0; s < NUM_SLOTS; s++) begin
            for (i = 0; i < 4; i++) begin
                a = slot_addr_t'($urandom);
                issue_request(s, 1'b0, a, '0, 2'b11);
                finish_access("read_path", s, 1'b0, a, '0, 2'b11, got);
                check_word("read_path", ref_word(ref_sdram_addr(s, a)), got);
            end
        end
        report_test("read_path", start);
    endtask

    task automatic test_write_mask();
        int         start;
        int         i;
        slot_addr_t a;
        word_t      d;
        word_t      exp;
        word_t      got;
        byte_mask_t m;
        start = errors;
        for (i = 0; i < 6; i++) begin
            a = slot_addr_t'(20'h0_1000 + 3 * i);
            d = word_t'($urandom);
            m = byte_mask_t'($urandom_range(3, 0));
            exp = ref_merge(ref_word(ref_sdram_addr(SLOT_RAM, a)), d, m);
            issue_request(SLOT_RAM, 1'b1, a, d, m);
            finish_access("write_mask", SLOT_RAM, 1'b1, a, d, m, got);
            issue_request(SLOT_RAM, 1'b0, a, '0, 2'b11);
            finish_access("write_mask", SLOT_RAM, 1'b0, a, '0, 2'b11, got);
            check_word("write_mask", exp, got);
        end
        report_test("write_mask", start);
    endtask

    task automatic test_priority();
        int                   start;
        int                   s;
        int                   n;
        logic                 req_prev;
        logic [NUM_SLOTS-1:0] done;
        sdram_addr_t          order [$];
        start = errors;
        @(posedge VB);
        for (s = 0; s < NUM_SLOTS; s++) begin
            slot_req[s] <= '{cs: 1'b1, wr: 1'b0, addr: slot_addr_t'(20'h40 + s),
                             din: '0, wrmask: 2'b11};
        end
        done = '0;
        req_prev = 1'b0;
        n = 0;
        while (done != '1 && n < 4 * TIMEOUT) begin
            @(posedge VB);
            n++;
            if (sdram_req && !req_prev) order.push_back(sdram_addr);
            req_prev = sdram_req;
            for (s = 0; s < NUM_SLOTS; s++) begin
                if (slot_rsp[s].ok && !done[s]) begin
                    done[s] = 1'b1;
                    slot_req[s].cs <= 1'b0;
                    check_word("priority", ref_word(ref_sdram_addr(s, slot_addr_t'(20'h40 + s))),
                               slot_rsp[s].dout);
                end
            end
        end
        if (done != '1) report_timeout("priority", "an ok on every slot");
        check_count("priority", NUM_SLOTS, order.size());
        for (s = 0; s < NUM_SLOTS && s < order.size(); s++) begin
            check_addr("priority", ref_sdram_addr(s, slot_addr_t'(20'h40 + s)), order[s]);
        end
        report_test("priority", start);
    endtask

    task automatic test_download();
        int         start;
        int         i;
        int         n;
        logic       is_rom;
        dl_addr_t   ba;
        logic [7:0] bd;
        slot_addr_t held;
        word_t      got;
        start = errors;
        held = 20'h0_0321;
        @(posedge VB);
        downloading <= 1'b1;
        // Held until the download ends
        issue_request(SLOT_GFX, 1'b0, held, '0, 2'b11);
        for (i = 0; i < 6; i++) begin
            ba = (i < 4) ? dl_addr_t'(23'h00_0200 + i) : CFG_START + dl_addr_t'(i);
            bd = 8'($urandom);
            is_rom = (ba < CFG_START);
            @(posedge VB);
            ioctl_addr <= ba;
            ioctl_data <= bd;
            ioctl_wr   <= 1'b1;
            @(posedge VB);
            ioctl_wr   <= 1'b0;
            n = 0;
            do begin
                @(posedge VB);
                n++;
            end while (!prog_we && !cfg_we && n < TIMEOUT);
            if (!prog_we && !cfg_we) begin
                report_timeout("download", "prog_we or cfg_we");
            end else if (prog_we !== is_rom || cfg_we === is_rom) begin
                errors++;
                $display("download: wrong strobe for byte address %h", ba);
            end else begin
                check_word("download", word_t'(bd), word_t'(prog_data));
                if (is_rom) begin
                    check_addr("download", sdram_addr_t'(ba >> 1), prog_addr);
                    check_mask("download", ref_prog_mask(ba), prog_mask);
                    n = 0;
                    do begin
                        @(posedge VB);
                        n++;
                    end while (prog_we && n < TIMEOUT);
                    if (prog_we) report_timeout("download", "prog_we to fall");
                end
            end
        end
        @(posedge VB);
        downloading <= 1'b0;
        finish_access("download", SLOT_GFX, 1'b0, held, '0, 2'b11, got);
        check_word("download", ref_word(ref_sdram_addr(SLOT_GFX, held)), got);
        if (req_in_download) begin
            errors++;
            $display("download: sdram_req went high while downloading");
        end
        report_test("download", start);
    endtask

    initial begin
        void'($urandom(46009));
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        slot_req    = '0;
        repeat (10) @(posedge VB);
        rst_n <= 1'b1;
        repeat (2) @(posedge VB);
        test_clock_enable();
        test_read_path();
        test_write_mask();
        test_priority();
        test_download();
        repeat (5) @(posedge VB);
        errors += u_game_mem_top.u_mem_checker.fail_count;
        $display("tests 5, failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/mem_pkg.sv
src/frac_cen.sv
src/prom_writer.sv
src/sdram_slot_mux.sv
src/game_mem_top.sv
verif/mem_checker.sv
verif/tb_game_mem.sv

// ==== Makefile ====
TOP := tb_game_mem

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -qx "test passed" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
